// File: Bender.yml
package:
  name: copper

sources:
  - copper_pkg.sv
  - copper_decode.sv
  - copper_execute.sv
  - copper_result.sv
  - copper_top.sv
  - target: test
    files:
      - tb_copper_env.sv
      - tb_copper.sv

// File: copper_decode.sv
// purely combinational; fields that do not belong to the current opcode are don't-care
module copper_decode (
    input  copper_pkg::word_t       instr_i,    // instruction word entering or held in IR
    output copper_pkg::copp_instr_t dec_o       // decoded fields
);

    always_comb begin
        dec_o.opcode      = copper_pkg::copp_opcode_t'(instr_i[copper_pkg::B_OPCODE +: 2]);
        dec_o.two_word    = !instr_i[copper_pkg::B_OPCODE + 1]; // SETI and SETM
        dec_o.wait_v      = instr_i[copper_pkg::B_ARG];
        dec_o.branch_on_b = instr_i[copper_pkg::B_ARG];         // same bit, other opcode
        dec_o.src_ra      = instr_i[copper_pkg::COP_XREG];
        dec_o.arg10       = instr_i[copper_pkg::B_ARG10:0];
        // beam counters are one bit wider than im10
        dec_o.wait_val    = {1'b0, instr_i[copper_pkg::B_ARG10:0]};
    end

endmodule

// File: copper_execute.sv
// program memory must answer one cycle after the read strobe; no read/write hazard delay
module copper_execute (
    input  logic                    clk,
    input  logic                    cop_reset,
    input  logic                    cop_xreg_wr_i,      // control register strobe
    input  copper_pkg::word_t       cop_xreg_data_i,    // bit 15 is enable
    input  copper_pkg::hres_t       h_count_i,          // beam x
    input  copper_pkg::vres_t       v_count_i,          // beam y
    input  logic                    end_of_line_i,
    output logic                    copmem_rd_en_o,
    output copper_pkg::copp_addr_t  copmem_rd_addr_o,
    input  copper_pkg::word_t       copmem_rd_data_i,
    input  copper_pkg::word_t       ra_i,               // accumulator for SETM from RA
    input  logic                    borrow_i,           // flag for BRGE/BRLT
    output copper_pkg::copp_write_t wr_req_o,           // to result stage
    output logic                    prog_restart_o      // held while disabled, pulsed at frame end
);

    logic                       cop_en;         // copper running
    logic                       restart;        // clears the sequencer
    copper_pkg::copp_ex_state_t state;
    copper_pkg::copp_addr_t     pc;
    copper_pkg::copp_addr_t     pc_next;
    copper_pkg::word_t          ir;
    copper_pkg::word_t          ir_in;          // IR input, word being decoded
    copper_pkg::copp_instr_t    dec;
    logic                       rd_pipeline;    // read strobe was high last cycle
    logic                       wait_hv;        // stalled on a beam compare
    logic                       wait_for_v;     // compare against v, else h
    copper_pkg::hres_t          wait_val;
    logic                       beam_reached;

    assign restart = cop_reset | prog_restart_o;
    assign pc_next = pc + 1'b1;

    // in fetch the arriving word is decoded so the 2nd word prefetch can start at once
    assign ir_in = (state == copper_pkg::ST_FETCH && rd_pipeline) ? copmem_rd_data_i : ir;

    assign beam_reached = wait_for_v ? (v_count_i >= wait_val) : (h_count_i >= wait_val);

    copper_decode u_decode (
        .instr_i (ir_in),
        .dec_o   (dec)
    );

    // enable flag and frame restart
    always_ff @(posedge clk) begin
        if (cop_reset) begin
            cop_en         <= 1'b0;
            prog_restart_o <= 1'b1;                     // disabled means held in restart
        end else begin
            prog_restart_o <= !cop_en || (end_of_line_i &&
                (v_count_i == copper_pkg::vres_t'(copper_pkg::TOTAL_HEIGHT - 1)));
            if (cop_xreg_wr_i) begin
                cop_en <= cop_xreg_data_i[15];
            end
        end
    end

    // sequencer
    always_ff @(posedge clk) begin
        if (restart) begin
            state            <= copper_pkg::ST_FETCH;
            pc               <= '0;
            ir               <= '0;
            rd_pipeline      <= 1'b0;
            wait_hv          <= 1'b0;
            wait_for_v       <= 1'b0;
            wait_val         <= '0;
            copmem_rd_en_o   <= 1'b0;
            copmem_rd_addr_o <= '0;
            wr_req_o         <= '0;
        end else begin
            copmem_rd_en_o   <= 1'b0;                   // strobes default low
            copmem_rd_addr_o <= pc;                     // reads are at pc unless SETM source
            wr_req_o.valid   <= 1'b0;
            rd_pipeline      <= copmem_rd_en_o;         // data due this cycle

            if (beam_reached) begin
                wait_hv <= 1'b0;                        // release beam wait
            end

            case (state)
                copper_pkg::ST_FETCH: begin
                    if (!rd_pipeline) begin
                        // start a read unless stalled or one is already out
                        if (!wait_hv && !copmem_rd_en_o) begin
                            copmem_rd_en_o <= 1'b1;
                            pc             <= pc_next;
                        end
                    end else begin
                        ir <= ir_in;
                        if (dec.two_word) begin
                            copmem_rd_en_o <= 1'b1;     // prefetch operand word
                            pc             <= pc_next;
                        end
                        state <= copper_pkg::ST_DECODE;
                    end
                end

                copper_pkg::ST_DECODE: begin
                    case (dec.opcode)
                        copper_pkg::OP_SETI: begin
                            if (rd_pipeline) begin      // immediate has arrived
                                wr_req_o.valid <= 1'b1;
                                wr_req_o.addr  <= ir;   // first word is the dest
                                wr_req_o.data  <= copmem_rd_data_i;
                                copmem_rd_en_o <= 1'b1; // next fetch overlaps the write
                                pc             <= pc_next;
                                state          <= copper_pkg::ST_FETCH;
                            end
                        end
                        copper_pkg::OP_MOVE: begin
                            // source read goes out behind the dest word already in flight
                            copmem_rd_en_o   <= 1'b1;
                            copmem_rd_addr_o <= dec.arg10;
                            state            <= copper_pkg::ST_SETR_RD;
                        end
                        copper_pkg::OP_HVPOS: begin
                            wait_hv    <= 1'b1;         // overrides the release above
                            wait_for_v <= dec.wait_v;
                            wait_val   <= dec.wait_val;
                            state      <= copper_pkg::ST_FETCH;
                        end
                        copper_pkg::OP_BRCC: begin
                            if (borrow_i == dec.branch_on_b) begin
                                pc <= dec.arg10;        // taken
                            end
                            state <= copper_pkg::ST_FETCH;
                        end
                    endcase
                end

                copper_pkg::ST_SETR_RD: begin
                    wr_req_o.addr <= copmem_rd_data_i;  // second word is the dest
                    state         <= copper_pkg::ST_SETR_WR;
                end

                copper_pkg::ST_SETR_WR: begin
                    wr_req_o.valid <= 1'b1;
                    wr_req_o.data  <= dec.src_ra ? ra_i : copmem_rd_data_i;
                    copmem_rd_en_o <= 1'b1;             // fetch next opcode
                    pc             <= pc_next;
                    state          <= copper_pkg::ST_FETCH;
                end
            endcase
        end
    end

endmodule

// File: copper_pkg.sv
// copper types and constants; assumes a 1024-word program memory, 11-bit beam counters and 525 lines
package copper_pkg;

    localparam int COPP_W       = 10;           // program memory address width
    localparam int TOTAL_HEIGHT = 525;          // lines per frame, blanking included

    typedef logic [15:0]       word_t;          // data word, XR bus and program memory
    typedef logic [15:0]       addr_t;          // XR bus address
    typedef logic [COPP_W-1:0] copp_addr_t;     // program memory address
    typedef logic [10:0]       hres_t;          // horizontal beam position
    typedef logic [10:0]       vres_t;          // vertical beam position

    // instruction word layout
    localparam int B_OPCODE     = 12;           // opcode sits in bits 13:12
    localparam int B_ARG        = 11;           // HPOS/VPOS select or BRGE/BRLT polarity
    localparam int B_ARG10      = 9;            // msb of im10 / cadr10

    // pseudo register addressing
    localparam int COP_XREG     = 10;           // pseudo reg select, RA source in SETM word 1
    localparam int COP_XREG_SUB = 0;            // 0 loads RA, 1 subtracts from RA

    localparam logic [1:0] XR_CONFIG_REGION = 2'b00;    // addr bits 15:14 of config regs

    // bits 13:12 of the first word
    typedef enum logic [1:0] {
        OP_SETI  = 2'b00,                       // SETI xadr14,#im16
        OP_MOVE  = 2'b01,                       // SETM xadr16,cadr10
        OP_HVPOS = 2'b10,                       // HPOS/VPOS #im10
        OP_BRCC  = 2'b11                        // BRGE/BRLT cadr10
    } copp_opcode_t;

    typedef enum logic [1:0] {
        ST_FETCH   = 2'b00,                     // fetch, also parks here on a beam wait
        ST_DECODE  = 2'b01,                     // act on IR
        ST_SETR_RD = 2'b10,                     // SETM dest word arriving
        ST_SETR_WR = 2'b11                      // SETM source word arriving, issue write
    } copp_ex_state_t;

    // decoded view of one instruction word
    typedef struct packed {
        copp_opcode_t opcode;
        logic         two_word;                 // SETI/SETM carry a second word
        logic         wait_v;                   // VPOS when set, else HPOS
        logic         branch_on_b;              // BRLT when set, else BRGE
        logic         src_ra;                   // SETM takes RA instead of memory
        copp_addr_t   arg10;                    // branch target or SETM source
        hres_t        wait_val;                 // im10 widened to beam width
    } copp_instr_t;

    // write request from sequencer to result stage, valid is a one cycle strobe
    typedef struct packed {
        logic  valid;
        addr_t addr;
        word_t data;
    } copp_write_t;

endpackage

// File: copper_result.sv
// the copper never waits for xr_wr_ack_i, a new bus write replaces one still pending
module copper_result (
    input  logic                    clk,
    input  logic                    cop_reset,
    input  logic                    prog_restart_i,     // clears RA and drops the bus write
    input  copper_pkg::copp_write_t wr_req_i,           // strobe from sequencer
    input  logic                    xr_wr_ack_i,
    output logic                    xr_wr_en_o,         // high until acked
    output copper_pkg::addr_t       xr_wr_addr_o,
    output copper_pkg::word_t       xr_wr_data_o,
    output copper_pkg::word_t       ra_o,               // accumulator
    output logic                    borrow_o            // RA < data of last write
);

    logic [16:0] ra_diff;       // {borrow, RA - data}
    logic        to_pseudo;     // request targets RA or RA_SUB

    assign ra_diff   = {1'b0, ra_o} - {1'b0, wr_req_i.data};
    assign to_pseudo = (wr_req_i.addr[15:14] == copper_pkg::XR_CONFIG_REGION) &&
                       wr_req_i.addr[copper_pkg::COP_XREG];

    // RA, borrow and bus enable
    always_ff @(posedge clk) begin
        if (cop_reset || prog_restart_i) begin
            ra_o       <= '0;
            borrow_o   <= 1'b0;
            xr_wr_en_o <= 1'b0;
        end else begin
            if (xr_wr_ack_i) begin
                xr_wr_en_o <= 1'b0;                     // bus took it
            end
            if (wr_req_i.valid) begin
                borrow_o <= ra_diff[16];                // every write compares with RA
                if (!to_pseudo) begin
                    xr_wr_en_o <= 1'b1;                 // wins over a same-cycle ack
                end else if (wr_req_i.addr[copper_pkg::COP_XREG_SUB]) begin
                    ra_o <= ra_diff[15:0];              // RA_SUB
                end else begin
                    ra_o     <= wr_req_i.data;          // plain load
                    borrow_o <= 1'b0;                   // load leaves B clear
                end
            end
        end
    end

    // bus payload, only meaningful while xr_wr_en_o is high
    always_ff @(posedge clk) begin
        if (wr_req_i.valid && !to_pseudo) begin
            xr_wr_addr_o <= wr_req_i.addr;
            xr_wr_data_o <= wr_req_i.data;
        end
    end

endmodule

// File: copper_top.sv
// XR bus acks may come any time after the enable; program memory has one cycle read latency
module copper_top (
    input  logic                   clk,
    input  logic                   cop_reset,
    // XR register bus
    output logic                   xr_wr_en_o,
    output copper_pkg::addr_t      xr_wr_addr_o,
    output copper_pkg::word_t      xr_wr_data_o,
    input  logic                   xr_wr_ack_i,
    // copper program memory
    output logic                   copmem_rd_en_o,
    output copper_pkg::copp_addr_t copmem_rd_addr_o,
    input  copper_pkg::word_t      copmem_rd_data_i,
    // control register, bit 15 enables
    input  logic                   cop_xreg_wr_i,
    input  copper_pkg::word_t      cop_xreg_data_i,
    // beam position
    input  copper_pkg::hres_t      h_count_i,
    input  copper_pkg::vres_t      v_count_i,
    input  logic                   end_of_line_i
);

    copper_pkg::copp_write_t wr_req;        // sequencer to result
    copper_pkg::word_t       ra;
    logic                    borrow;
    logic                    prog_restart;

    copper_execute u_execute (
        .clk              (clk),
        .cop_reset        (cop_reset),
        .cop_xreg_wr_i    (cop_xreg_wr_i),
        .cop_xreg_data_i  (cop_xreg_data_i),
        .h_count_i        (h_count_i),
        .v_count_i        (v_count_i),
        .end_of_line_i    (end_of_line_i),
        .copmem_rd_en_o   (copmem_rd_en_o),
        .copmem_rd_addr_o (copmem_rd_addr_o),
        .copmem_rd_data_i (copmem_rd_data_i),
        .ra_i             (ra),
        .borrow_i         (borrow),
        .wr_req_o         (wr_req),
        .prog_restart_o   (prog_restart)
    );

    copper_result u_result (
        .clk              (clk),
        .cop_reset        (cop_reset),
        .prog_restart_i   (prog_restart),
        .wr_req_i         (wr_req),
        .xr_wr_ack_i      (xr_wr_ack_i),
        .xr_wr_en_o       (xr_wr_en_o),
        .xr_wr_addr_o     (xr_wr_addr_o),
        .xr_wr_data_o     (xr_wr_data_o),
        .ra_o             (ra),
        .borrow_o         (borrow)
    );

endmodule

// File: list.f
copper_pkg.sv
copper_decode.sv
copper_execute.sv
copper_result.sv
copper_top.sv
tb_copper_env.sv
tb_copper.sv

// File: tb_copper.sv
// directed tests of copper_top; programs go straight into the memory model while the copper is off
module tb_copper;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int          PERIOD       = 20;
    localparam int          RESET_CYCLES = 8;
    localparam logic [31:0] SEED         = 32'h4d61ec1d;
    localparam int          WAIT_CYCLES  = 4000;    // two lines plus an HPOS fit easily
    localparam int          SETTLE       = 100;     // quiet cycles before a queue is compared
    localparam int          N_RUNS       = 9;       // program runs over all tests
    localparam int          TEST_CYCLES  = RESET_CYCLES + 300 +
                                           N_RUNS * (WAIT_CYCLES + SETTLE + 20);
    localparam int          WATCHDOG_NS  = TEST_CYCLES * PERIOD + 20000;

    localparam copper_pkg::word_t EN_ON    = 16'h8000;
    localparam copper_pkg::word_t EN_OFF   = 16'h0000;
    localparam copper_pkg::word_t RA_LOAD  = 16'h0400;  // SETI target, pseudo reg RA
    localparam copper_pkg::word_t RA_SUB   = 16'h0401;  // SETI target, RA minus data
    localparam copper_pkg::word_t VPOS_END = 16'h2BFF;  // VPOS 1023, parks till frame restart
    localparam int                V_START  = 100;       // beam line for the wait test
    localparam int                VPOS_N   = 102;
    localparam int                HPOS_N   = 300;

    typedef struct packed {
        copper_pkg::addr_t addr;
        copper_pkg::word_t data;
        copper_pkg::hres_t h;                           // beam position when the bus took it
        copper_pkg::vres_t v;
    } bus_write_t;

    logic                   clk = 1'b0;
    logic                   cop_reset;
    logic                   xr_wr_en;
    copper_pkg::addr_t      xr_wr_addr;
    copper_pkg::word_t      xr_wr_data;
    logic                   xr_wr_ack;
    logic                   copmem_rd_en;
    copper_pkg::copp_addr_t copmem_rd_addr;
    copper_pkg::word_t      copmem_rd_data;
    logic                   cop_xreg_wr;
    copper_pkg::word_t      cop_xreg_data;
    copper_pkg::hres_t      h_count;
    copper_pkg::vres_t      v_count;
    logic                   end_of_line;
    logic                   beam_load;
    copper_pkg::vres_t      beam_v;

    bus_write_t got_q[$];                               // writes acked on the bus
    bus_write_t exp_q[$];                               // writes the program should make
    int         prog_ptr;                               // next free program address
    int         errors = 0;
    int         checks = 0;

    copper_top DUT (
        .clk              (clk),
        .cop_reset        (cop_reset),
        .xr_wr_en_o       (xr_wr_en),
        .xr_wr_addr_o     (xr_wr_addr),
        .xr_wr_data_o     (xr_wr_data),
        .xr_wr_ack_i      (xr_wr_ack),
        .copmem_rd_en_o   (copmem_rd_en),
        .copmem_rd_addr_o (copmem_rd_addr),
        .copmem_rd_data_i (copmem_rd_data),
        .cop_xreg_wr_i    (cop_xreg_wr),
        .cop_xreg_data_i  (cop_xreg_data),
        .h_count_i        (h_count),
        .v_count_i        (v_count),
        .end_of_line_i    (end_of_line)
    );

    tb_copper_env u_env (
        .clk              (clk),
        .cop_reset        (cop_reset),
        .copmem_rd_en_i   (copmem_rd_en),
        .copmem_rd_addr_i (copmem_rd_addr),
        .copmem_rd_data_o (copmem_rd_data),
        .xr_wr_en_i       (xr_wr_en),
        .xr_wr_ack_o      (xr_wr_ack),
        .beam_load_i      (beam_load),
        .beam_v_i         (beam_v),
        .h_count_o        (h_count),
        .v_count_o        (v_count),
        .end_of_line_o    (end_of_line)
    );

    always #(PERIOD / 2) clk = ~clk;

    // a write counts once, in the cycle where enable and ack are both high
    always @(negedge clk) begin : bus_monitor
        bus_write_t w;
        if (xr_wr_en && xr_wr_ack) begin
            w.addr = xr_wr_addr;
            w.data = xr_wr_data;
            w.h    = h_count;
            w.v    = v_count;
            got_q.push_back(w);
        end
    end

    task automatic check_value(input string sig, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("FAILED at %0t ns: %s = %h, expected %h", $time, sig, got, exp);
        end
    endtask

    task automatic check_cond(input bit ok, input string what);
        checks++;
        assert (ok) else begin
            errors++;
            $display("ERROR at %0t ns: %s", $time, what);
        end
    endtask

    // stray SETI fill, a program that runs off its end shows up as extra writes
    task automatic clear_program();
        int a;
        for (a = 0; a < (1 << copper_pkg::COPP_W); a++) begin
            u_env.mem[a] = 16'hC000 | 16'(a);
        end
        prog_ptr = 0;
        exp_q.delete();
    endtask

    task automatic emit(input copper_pkg::word_t w);
        u_env.mem[prog_ptr] = w;
        prog_ptr++;
    endtask

    task automatic expect_write(input copper_pkg::addr_t addr, input copper_pkg::word_t data);
        bus_write_t w;
        w      = '0;
        w.addr = addr;
        w.data = data;
        exp_q.push_back(w);
    endtask

    task automatic write_ctrl(input copper_pkg::word_t data);
        @(posedge clk);
        cop_xreg_wr   <= 1'b1;
        cop_xreg_data <= data;
        @(posedge clk);
        cop_xreg_wr   <= 1'b0;
    endtask

    task automatic start_copper(input int line);
        @(posedge clk);
        beam_load <= 1'b1;                              // beam to start of line
        beam_v    <= copper_pkg::vres_t'(line);
        @(posedge clk);
        beam_load <= 1'b0;
        got_q.delete();
        write_ctrl(EN_ON);
    endtask

    task automatic stop_copper();
        write_ctrl(EN_OFF);
        repeat (4) @(posedge clk);                      // restart has reached both stages
    endtask

    task automatic wait_writes(input int n);
        int cycles;
        cycles = 0;
        while (got_q.size() < n && cycles < WAIT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        check_cond(got_q.size() >= n,
                   $sformatf("timed out waiting for %0d bus writes, saw %0d", n, got_q.size()));
    endtask

    task automatic settle_and_compare();
        int i;
        repeat (SETTLE) @(posedge clk);
        check_cond(got_q.size() == exp_q.size(),
                   $sformatf("expected %0d bus writes, saw %0d", exp_q.size(), got_q.size()));
        for (i = 0; i < exp_q.size() && i < got_q.size(); i++) begin
            check_value("xr_wr_addr_o", got_q[i].addr, exp_q[i].addr);
            check_value("xr_wr_data_o", got_q[i].data, exp_q[i].data);
        end
    endtask

    task automatic enable_disable_check();
        int taken;
        int i;
        clear_program();
        emit(16'h8300);                                 // SETI 0x8300,#0
        emit(16'h0000);                                 // zero data keeps borrow clear
        emit(16'h3000);                                 // BRGE 0, endless loop
        got_q.delete();
        repeat (50) begin
            @(negedge clk);
            check_cond(!xr_wr_en && !copmem_rd_en, "strobe active while the copper is disabled");
        end
        start_copper(0);
        wait_writes(3);
        write_ctrl(EN_OFF);
        repeat (3) @(posedge clk);
        taken = got_q.size();
        repeat (200) begin
            @(negedge clk);
            check_cond(!xr_wr_en && !copmem_rd_en, "strobe active after the copper was disabled");
        end
        check_cond(got_q.size() == taken, "bus writes went on after the copper was disabled");
        for (i = 0; i < got_q.size(); i++) begin
            check_value("xr_wr_addr_o", got_q[i].addr, 16'h8300);
            check_value("xr_wr_data_o", got_q[i].data, 16'h0000);
        end
    endtask

    task automatic seti_sequence();
        int                i;
        copper_pkg::addr_t adr;
        copper_pkg::word_t imm;
        clear_program();
        for (i = 0; i < 8; i++) begin
            adr = {4'b1000, 12'($urandom)};             // bits 13:12 clear, outside config region
            imm = 16'($urandom);
            emit(adr);
            emit(imm);
            expect_write(adr, imm);
        end
        emit(VPOS_END);
        start_copper(0);
        wait_writes(8);
        settle_and_compare();
        stop_copper();
    endtask

    task automatic setm_and_ra();
        copper_pkg::word_t src;
        copper_pkg::word_t a;
        copper_pkg::word_t b;
        src = 16'($urandom);
        a   = 16'($urandom);
        b   = 16'($urandom);
        clear_program();
        emit(16'h1200);                                 // SETM from memory word 0x200
        emit(16'h8100);
        emit(RA_LOAD);
        emit(a);
        emit(RA_SUB);
        emit(b);
        emit(16'h1400);                                 // SETM with RA as source
        emit(16'h8101);
        emit(VPOS_END);
        u_env.mem[10'h200] = src;
        expect_write(16'h8100, src);
        expect_write(16'h8101, a - b);                  // wraps to 16 bits
        start_copper(0);
        wait_writes(2);
        settle_and_compare();
        stop_copper();
    endtask

    task automatic run_branch(input bit brlt, input copper_pkg::word_t a,
                              input copper_pkg::word_t b);
        bit taken;
        taken = ((a < b) == brlt);                      // borrow of a - b against polarity
        clear_program();
        emit(RA_LOAD);
        emit(a);
        emit(RA_SUB);
        emit(b);
        emit(brlt ? 16'h3808 : 16'h3008);               // BRLT / BRGE to address 8
        emit(16'h8200);                                 // fall through mark
        emit(16'h00A0);
        emit(VPOS_END);
        emit(16'h8201);                                 // address 8, branch target mark
        emit(16'h00B1);
        emit(VPOS_END);
        if (taken) begin
            expect_write(16'h8201, 16'h00B1);
        end else begin
            expect_write(16'h8200, 16'h00A0);
        end
        start_copper(0);
        wait_writes(1);
        settle_and_compare();
        stop_copper();
    endtask

    task automatic branch_on_borrow();
        copper_pkg::word_t lo;
        copper_pkg::word_t hi;
        lo = {1'b0, 15'($urandom)};                     // always below hi
        hi = {1'b1, 15'($urandom)};
        run_branch(1'b1, lo, hi);
        run_branch(1'b1, hi, lo);
        run_branch(1'b0, lo, hi);
        run_branch(1'b0, hi, hi);                       // equal, no borrow
    endtask

    task automatic beam_waits();
        copper_pkg::word_t d0;
        copper_pkg::word_t d1;
        copper_pkg::word_t d2;
        d0 = 16'($urandom);
        d1 = 16'($urandom);
        d2 = 16'($urandom);
        clear_program();
        emit(16'h8500);
        emit(d0);
        emit(16'h2800 | 16'(VPOS_N));                   // VPOS
        emit(16'h8501);
        emit(d1);
        emit(16'h2000 | 16'(HPOS_N));                   // HPOS
        emit(16'h8502);
        emit(d2);
        emit(VPOS_END);
        expect_write(16'h8500, d0);
        expect_write(16'h8501, d1);
        expect_write(16'h8502, d2);
        start_copper(V_START);
        wait_writes(3);
        settle_and_compare();
        if (got_q.size() == 3) begin
            check_cond(got_q[0].v < VPOS_N, "write ahead of VPOS did not come before the wait");
            check_cond(got_q[1].v >= VPOS_N,
                       $sformatf("write after VPOS %0d came on line %0d", VPOS_N, got_q[1].v));
            check_cond(got_q[2].v == VPOS_N && got_q[2].h >= HPOS_N,
                       $sformatf("write after HPOS %0d came at h %0d line %0d",
                                 HPOS_N, got_q[2].h, got_q[2].v));
        end
        stop_copper();
    endtask

    task automatic frame_restart();
        copper_pkg::word_t first;
        first = 16'($urandom);
        clear_program();
        emit(16'h8600);
        emit(first);
        emit(VPOS_END);
        expect_write(16'h8600, first);
        expect_write(16'h8600, first);                  // again after the frame wraps
        start_copper(copper_pkg::TOTAL_HEIGHT - 2);
        wait_writes(2);
        settle_and_compare();
        if (got_q.size() == 2) begin
            check_cond(got_q[0].v == copper_pkg::TOTAL_HEIGHT - 2,
                       "first write did not come on the line where the copper started");
            check_cond(got_q[1].v == 0, "repeated write did not come at the start of the frame");
        end
        stop_copper();
    endtask

    initial begin
        void'($urandom(SEED));
        cop_reset     = 1'b1;
        cop_xreg_wr   = 1'b0;
        cop_xreg_data = '0;
        beam_load     = 1'b0;
        beam_v        = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        cop_reset <= 1'b0;
        enable_disable_check();
        seti_sequence();
        setm_and_ra();
        branch_on_borrow();
        beam_waits();
        frame_restart();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, %0d checks, %0d errors",
                 WATCHDOG_NS, checks, errors);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

// File: tb_copper_env.sv
// testbench models; memory answers one cycle after the strobe, ack one cycle after enable, 800x525 beam
module tb_copper_env (
    input  logic                   clk,
    input  logic                   cop_reset,
    // program memory port
    input  logic                   copmem_rd_en_i,
    input  copper_pkg::copp_addr_t copmem_rd_addr_i,
    output copper_pkg::word_t      copmem_rd_data_o,
    // XR bus
    input  logic                   xr_wr_en_i,
    output logic                   xr_wr_ack_o,
    // beam position
    input  logic                   beam_load_i,         // jump to the start of line beam_v_i
    input  copper_pkg::vres_t      beam_v_i,
    output copper_pkg::hres_t      h_count_o,
    output copper_pkg::vres_t      v_count_o,
    output logic                   end_of_line_o
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int H_TOTAL = 800;                       // pixels per line, blanking included

    copper_pkg::word_t mem [0:(1 << copper_pkg::COPP_W) - 1];  // filled by the test tasks

    initial begin
        copmem_rd_data_o = '0;
        xr_wr_ack_o      = 1'b0;
        h_count_o        = '0;
        v_count_o        = '0;
    end

    // registered read, data is there the cycle after the strobe
    always @(posedge clk) begin
        if (copmem_rd_en_i) begin
            copmem_rd_data_o <= mem[copmem_rd_addr_i];
        end
    end

    // ack rises one cycle after the enable and drops with the write taken
    always @(posedge clk) begin
        if (cop_reset) begin
            xr_wr_ack_o <= 1'b0;
        end else begin
            xr_wr_ack_o <= xr_wr_en_i && !xr_wr_ack_o;
        end
    end

    // beam counters
    always @(posedge clk) begin
        if (cop_reset || beam_load_i) begin
            h_count_o <= '0;
            v_count_o <= cop_reset ? '0 : beam_v_i;     // load sets the line, h from 0
        end else if (end_of_line_o) begin
            h_count_o <= '0;
            if (v_count_o == copper_pkg::vres_t'(copper_pkg::TOTAL_HEIGHT - 1)) begin
                v_count_o <= '0;                        // new frame
            end else begin
                v_count_o <= v_count_o + 1'b1;
            end
        end else begin
            h_count_o <= h_count_o + 1'b1;
        end
    end

    assign end_of_line_o = (h_count_o == copper_pkg::hres_t'(H_TOTAL - 1));  // last pixel

endmodule
